/* common/stream_pkg.sv */
package stream_pkg;

  // Default stream and FIFO geometry.
  localparam int STREAM_DATA_WIDTH = 8;
  localparam int STREAM_FIFO_ADDR_WIDTH = 4;  // 16 memory entries.

  // Status block widths.
  localparam int STAT_COUNT_WIDTH = 16;
  localparam int APB_ADDR_WIDTH = 5;

  typedef enum logic [1:0] {
    ARB_IDLE   = 2'd0,  // no grant held.
    ARB_PASS_A = 2'd1,
    ARB_PASS_B = 2'd2
  } arb_state_t;

  // byte addresses of the status registers.
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL   = 5'h00,  // write bit 0 to clear all counters.
    REG_PKT_A  = 5'h04,
    REG_PKT_B  = 5'h08,
    REG_BEAT_A = 5'h0C,
    REG_BEAT_B = 5'h10,
    REG_ERR    = 5'h14   // errored packets from both sources.
  } stat_reg_t;

endpackage

/* axis_async_fifo/axis_async_fifo.sv */
`timescale 1ns/1ps

module axis_async_fifo #(
  parameter int ADDR_WIDTH = stream_pkg::STREAM_FIFO_ADDR_WIDTH,
  parameter int DATA_WIDTH = stream_pkg::STREAM_DATA_WIDTH
) (
  input  logic                  async_rst,
  input  logic                  input_clk,
  input  logic [DATA_WIDTH-1:0] input_axis_tdata,
  input  logic                  input_axis_tvalid,
  output logic                  input_axis_tready,
  input  logic                  input_axis_tlast,
  input  logic                  input_axis_tuser,
  input  logic                  output_clk,
  output logic [DATA_WIDTH-1:0] output_axis_tdata,
  output logic                  output_axis_tvalid,
  input  logic                  output_axis_tready,
  output logic                  output_axis_tlast,
  output logic                  output_axis_tuser
);

  localparam int WORD_WIDTH = DATA_WIDTH + 2;

  logic [WORD_WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic [WORD_WIDTH-1:0] data_in;
  logic [WORD_WIDTH-1:0] data_out_reg;

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] rd_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync2;

  // the chains power up asserted so neither side runs before its first reset.
  logic input_rst_sync1 = 1'b1;
  logic input_rst_sync2 = 1'b1;
  logic input_rst_sync3 = 1'b1;
  logic output_rst_sync1 = 1'b1;
  logic output_rst_sync2 = 1'b1;
  logic output_rst_sync3 = 1'b1;

  logic output_axis_tvalid_reg;
  logic full;
  logic empty;
  logic write;
  logic read;

  function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  assign data_in = {input_axis_tlast, input_axis_tuser, input_axis_tdata};

  // full when the top two gray bits differ and the rest match.
  assign full = (wr_ptr_gray == {~rd_ptr_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                 rd_ptr_gray_sync2[ADDR_WIDTH-2:0]});
  assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

  assign write = input_axis_tvalid & ~full & ~input_rst_sync3;
  assign read = ~empty & (output_axis_tready | ~output_axis_tvalid_reg);

  assign input_axis_tready = ~full & ~input_rst_sync3;
  assign output_axis_tvalid = output_axis_tvalid_reg;
  assign {output_axis_tlast, output_axis_tuser, output_axis_tdata} = data_out_reg;

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  // the input side stays in reset until the output chain has released.
  always_ff @(posedge input_clk) begin
    if (async_rst) begin
      input_rst_sync1 <= 1'b1;
      input_rst_sync2 <= 1'b1;
      input_rst_sync3 <= 1'b1;
    end else begin
      input_rst_sync1 <= 1'b0;
      input_rst_sync2 <= input_rst_sync1 | output_rst_sync3;
      input_rst_sync3 <= input_rst_sync2;
    end
  end

  always_ff @(posedge output_clk) begin
    if (async_rst) begin
      output_rst_sync1 <= 1'b1;
      output_rst_sync2 <= 1'b1;
      output_rst_sync3 <= 1'b1;
    end else begin
      output_rst_sync1 <= 1'b0;
      output_rst_sync2 <= output_rst_sync1;
      output_rst_sync3 <= output_rst_sync2;
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= data_in;
    end
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr <= wr_ptr_next;
      wr_ptr_gray <= bin2gray(wr_ptr_next);
    end
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr <= '0;
      rd_ptr_gray <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr_next;
      rd_ptr_gray <= bin2gray(rd_ptr_next);
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  // output register refills whenever it is empty or being consumed.
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      output_axis_tvalid_reg <= 1'b0;
    end else if (output_axis_tready | ~output_axis_tvalid_reg) begin
      output_axis_tvalid_reg <= ~empty;
    end
  end

endmodule

/* source/axis_packet_arbiter.sv */
`timescale 1ns/1ps

module axis_packet_arbiter #(
  parameter int DATA_WIDTH = stream_pkg::STREAM_DATA_WIDTH
) (
  input  logic                  output_clk,
  input  logic                  output_rst_sync3,
  input  logic [DATA_WIDTH-1:0] a_axis_tdata,
  input  logic                  a_axis_tvalid,
  output logic                  a_axis_tready,
  input  logic                  a_axis_tlast,
  input  logic                  a_axis_tuser,
  input  logic [DATA_WIDTH-1:0] b_axis_tdata,
  input  logic                  b_axis_tvalid,
  output logic                  b_axis_tready,
  input  logic                  b_axis_tlast,
  input  logic                  b_axis_tuser,
  output logic [DATA_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,
  output logic                  m_axis_tuser,
  output logic                  m_axis_tid
);

  import stream_pkg::*;

  arb_state_t state;
  arb_state_t state_next;
  logic last_grant_b;  // set when B held the most recent grant.
  logic pass_a;
  logic pass_b;
  logic last_xfer;

  assign pass_a = (state == ARB_PASS_A);
  assign pass_b = (state == ARB_PASS_B);

  // the granted source drives the output, the other one sees tready low.
  assign m_axis_tdata = pass_b ? b_axis_tdata : a_axis_tdata;
  assign m_axis_tlast = pass_b ? b_axis_tlast : a_axis_tlast;
  assign m_axis_tuser = pass_b ? b_axis_tuser : a_axis_tuser;
  assign m_axis_tvalid = (pass_a & a_axis_tvalid) | (pass_b & b_axis_tvalid);
  assign m_axis_tid = pass_b;
  assign a_axis_tready = pass_a & m_axis_tready;
  assign b_axis_tready = pass_b & m_axis_tready;

  assign last_xfer = m_axis_tvalid & m_axis_tready & m_axis_tlast;

  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: begin
        if (a_axis_tvalid && (!b_axis_tvalid || last_grant_b)) begin
          state_next = ARB_PASS_A;
        end else if (b_axis_tvalid) begin
          state_next = ARB_PASS_B;
        end
      end
      ARB_PASS_A, ARB_PASS_B: begin
        if (last_xfer) begin
          state_next = ARB_IDLE;  // one idle cycle between packets.
        end
      end
      default: begin
        state_next = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      state <= ARB_IDLE;
      last_grant_b <= 1'b1;  // A wins the first tie.
    end else begin
      state <= state_next;
      if (state == ARB_IDLE && state_next != ARB_IDLE) begin
        last_grant_b <= (state_next == ARB_PASS_B);
      end
    end
  end

endmodule

/* source/stream_stat_apb.sv */
`timescale 1ns/1ps

module stream_stat_apb (
  input  logic                                output_clk,
  input  logic                                output_rst_sync3,
  input  logic                                beat_valid,
  input  logic                                beat_ready,
  input  logic                                beat_last,
  input  logic                                beat_user,
  input  logic                                beat_id,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [stream_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata
);

  import stream_pkg::*;

  logic [STAT_COUNT_WIDTH-1:0] pkt_a_cnt;
  logic [STAT_COUNT_WIDTH-1:0] pkt_b_cnt;
  logic [STAT_COUNT_WIDTH-1:0] beat_a_cnt;
  logic [STAT_COUNT_WIDTH-1:0] beat_b_cnt;
  logic [STAT_COUNT_WIDTH-1:0] err_cnt;
  logic beat_fire;
  logic last_fire;
  logic clear;

  function automatic logic [STAT_COUNT_WIDTH-1:0] sat_inc(
    input logic [STAT_COUNT_WIDTH-1:0] cnt
  );
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  assign beat_fire = beat_valid & beat_ready;
  assign last_fire = beat_fire & beat_last;

  // a write lands at the end of the access cycle.
  assign clear = psel & penable & pwrite & (stat_reg_t'(paddr) == REG_CTRL) & pwdata[0];

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3 || clear) begin
      pkt_a_cnt <= '0;
      pkt_b_cnt <= '0;
      beat_a_cnt <= '0;
      beat_b_cnt <= '0;
      err_cnt <= '0;
    end else if (beat_fire) begin
      if (beat_id) begin
        beat_b_cnt <= sat_inc(beat_b_cnt);
      end else begin
        beat_a_cnt <= sat_inc(beat_a_cnt);
      end
      if (last_fire && beat_id) begin
        pkt_b_cnt <= sat_inc(pkt_b_cnt);
      end
      if (last_fire && !beat_id) begin
        pkt_a_cnt <= sat_inc(pkt_a_cnt);
      end
      if (last_fire && beat_user) begin
        err_cnt <= sat_inc(err_cnt);  // errored packet from either source.
      end
    end
  end

  // read data follows paddr, so it is ready in the access cycle.
  always_comb begin
    prdata = '0;
    case (stat_reg_t'(paddr))
      REG_PKT_A:  prdata = 32'(pkt_a_cnt);
      REG_PKT_B:  prdata = 32'(pkt_b_cnt);
      REG_BEAT_A: prdata = 32'(beat_a_cnt);
      REG_BEAT_B: prdata = 32'(beat_b_cnt);
      REG_ERR:    prdata = 32'(err_cnt);
      default:    prdata = '0;
    endcase
  end

endmodule

/* source/stream_merge_top.sv */
`timescale 1ns/1ps

module stream_merge_top #(
  parameter int DATA_WIDTH = stream_pkg::STREAM_DATA_WIDTH,
  parameter int ADDR_WIDTH = stream_pkg::STREAM_FIFO_ADDR_WIDTH
) (
  input  logic                                input_a_clk,
  input  logic [DATA_WIDTH-1:0]               input_a_axis_tdata,
  input  logic                                input_a_axis_tvalid,
  output logic                                input_a_axis_tready,
  input  logic                                input_a_axis_tlast,
  input  logic                                input_a_axis_tuser,
  input  logic                                input_b_clk,
  input  logic [DATA_WIDTH-1:0]               input_b_axis_tdata,
  input  logic                                input_b_axis_tvalid,
  output logic                                input_b_axis_tready,
  input  logic                                input_b_axis_tlast,
  input  logic                                input_b_axis_tuser,
  input  logic                                output_clk,
  input  logic                                output_rst_sync3,
  output logic [DATA_WIDTH-1:0]               output_axis_tdata,
  output logic                                output_axis_tvalid,
  input  logic                                output_axis_tready,
  output logic                                output_axis_tlast,
  output logic                                output_axis_tuser,
  output logic                                output_axis_tid,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [stream_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata
);

  logic [DATA_WIDTH-1:0] fifo_a_tdata;
  logic                  fifo_a_tvalid;
  logic                  fifo_a_tready;
  logic                  fifo_a_tlast;
  logic                  fifo_a_tuser;
  logic [DATA_WIDTH-1:0] fifo_b_tdata;
  logic                  fifo_b_tvalid;
  logic                  fifo_b_tready;
  logic                  fifo_b_tlast;
  logic                  fifo_b_tuser;

  // each FIFO takes the output domain reset and syncs it into its own clock.
  axis_async_fifo #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_fifo_a (
    .async_rst          (output_rst_sync3),
    .input_clk          (input_a_clk),
    .input_axis_tdata   (input_a_axis_tdata),
    .input_axis_tvalid  (input_a_axis_tvalid),
    .input_axis_tready  (input_a_axis_tready),
    .input_axis_tlast   (input_a_axis_tlast),
    .input_axis_tuser   (input_a_axis_tuser),
    .output_clk         (output_clk),
    .output_axis_tdata  (fifo_a_tdata),
    .output_axis_tvalid (fifo_a_tvalid),
    .output_axis_tready (fifo_a_tready),
    .output_axis_tlast  (fifo_a_tlast),
    .output_axis_tuser  (fifo_a_tuser)
  );

  axis_async_fifo #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_fifo_b (
    .async_rst          (output_rst_sync3),
    .input_clk          (input_b_clk),
    .input_axis_tdata   (input_b_axis_tdata),
    .input_axis_tvalid  (input_b_axis_tvalid),
    .input_axis_tready  (input_b_axis_tready),
    .input_axis_tlast   (input_b_axis_tlast),
    .input_axis_tuser   (input_b_axis_tuser),
    .output_clk         (output_clk),
    .output_axis_tdata  (fifo_b_tdata),
    .output_axis_tvalid (fifo_b_tvalid),
    .output_axis_tready (fifo_b_tready),
    .output_axis_tlast  (fifo_b_tlast),
    .output_axis_tuser  (fifo_b_tuser)
  );

  axis_packet_arbiter #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_arbiter (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .a_axis_tdata     (fifo_a_tdata),
    .a_axis_tvalid    (fifo_a_tvalid),
    .a_axis_tready    (fifo_a_tready),
    .a_axis_tlast     (fifo_a_tlast),
    .a_axis_tuser     (fifo_a_tuser),
    .b_axis_tdata     (fifo_b_tdata),
    .b_axis_tvalid    (fifo_b_tvalid),
    .b_axis_tready    (fifo_b_tready),
    .b_axis_tlast     (fifo_b_tlast),
    .b_axis_tuser     (fifo_b_tuser),
    .m_axis_tdata     (output_axis_tdata),
    .m_axis_tvalid    (output_axis_tvalid),
    .m_axis_tready    (output_axis_tready),
    .m_axis_tlast     (output_axis_tlast),
    .m_axis_tuser     (output_axis_tuser),
    .m_axis_tid       (output_axis_tid)
  );

  // the status block watches the merged output stream.
  stream_stat_apb u_stats (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .beat_valid       (output_axis_tvalid),
    .beat_ready       (output_axis_tready),
    .beat_last        (output_axis_tlast),
    .beat_user        (output_axis_tuser),
    .beat_id          (output_axis_tid),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata)
  );

endmodule

/* verification/stream_merge_tests.svh */
`ifndef STREAM_MERGE_TESTS_SVH
`define STREAM_MERGE_TESTS_SVH

task automatic reset_test();
  @(negedge output_clk);
  checks++;
  assert (!output_axis_tvalid) else begin
    errors++;
    $display("error at %0t: output tvalid high after reset", $time);
  end
  check_reg(REG_CTRL, 32'd0);
  check_reg(REG_PKT_A, 32'd0);
  check_reg(REG_PKT_B, 32'd0);
  check_reg(REG_BEAT_A, 32'd0);
  check_reg(REG_BEAT_B, 32'd0);
  check_reg(REG_ERR, 32'd0);
endtask

task automatic single_packet_test();
  send_packet(1'b0, 5);
  wait_drain();
endtask

task automatic concurrent_test();
  fork
    send_packets(1'b0, 6);
    send_packets(1'b1, 6);
  join
  wait_drain();
endtask

task automatic backpressure_test();
  ready_mode = 1;
  fork
    send_packets(1'b0, 5);
    send_packets(1'b1, 5);
  join
  wait_drain();
  ready_mode = 0;
endtask

// every beat is a one-beat packet, so the beat left waiting at the end is a whole packet.
task automatic fill_limit_test();
  logic [31:0] rnd;
  logic ready_seen;
  int accepted;
  int low_run;
  int waited;
  accepted = 0;
  low_run = 0;
  waited = 0;
  ready_mode = 2;
  wait_src_rise(1'b0);
  #1;
  rnd = $random(seed);
  {src_tlast[0], src_tuser[0], src_tdata[0]} = {2'b10, rnd[DW-1:0]};
  src_tvalid[0] = 1'b1;
  while (low_run < 50 && waited < 1000) begin
    @(negedge input_a_clk);
    ready_seen = src_tready[0];
    @(posedge input_a_clk);
    #1;
    waited++;
    if (ready_seen) begin
      expect_beat(1'b0, {2'b10, src_tdata[0]});
      accepted++;
      low_run = 0;
      rnd = $random(seed);
      src_tdata[0] = rnd[DW-1:0];
    end else begin
      low_run++;
    end
  end
  checks++;
  assert (low_run == 50) else begin
    errors++;
    $display("timeout: source A tready never stayed low for 50 cycles");
  end
  checks++;
  assert (accepted == FIFO_BEATS) else begin
    errors++;
    $display("error at %0t: source A took %0d beats with the output stalled, expected %0d",
             $time, accepted, FIFO_BEATS);
  end
  ready_mode = 0;
  send_beat(1'b0, {2'b10, src_tdata[0]});  // goes in once the FIFO drains.
  wait_drain();
endtask

task automatic counter_clear_test();
  logic [31:0] unused_rdata;
  check_reg(REG_PKT_A, sent_pkts[0]);
  check_reg(REG_PKT_B, sent_pkts[1]);
  check_reg(REG_BEAT_A, sent_beats[0]);
  check_reg(REG_BEAT_B, sent_beats[1]);
  check_reg(REG_ERR, sent_err);
  apb_access(1'b1, REG_CTRL, 32'h1, unused_rdata);
  check_reg(REG_PKT_A, 32'd0);
  check_reg(REG_PKT_B, 32'd0);
  check_reg(REG_BEAT_A, 32'd0);
  check_reg(REG_BEAT_B, 32'd0);
  check_reg(REG_ERR, 32'd0);
endtask

`endif

/* verification/stream_merge_tb.sv */
`timescale 1ns/1ps

module stream_merge_tb;

  import stream_pkg::*;

  localparam int DW = STREAM_DATA_WIDTH;
  localparam int FIFO_BEATS = (1 << STREAM_FIFO_ADDR_WIDTH) + 1;  // memory plus output register.

  logic output_clk;
  logic input_a_clk;
  logic input_b_clk;
  logic output_rst_sync3;
  logic [DW-1:0] src_tdata [2];  // index 0 is source A, 1 is source B.
  logic [1:0] src_tvalid;
  logic [1:0] src_tlast;
  logic [1:0] src_tuser;
  wire [1:0] src_tready;
  logic [DW-1:0] output_axis_tdata;
  logic output_axis_tvalid;
  logic output_axis_tready;
  logic output_axis_tlast;
  logic output_axis_tuser;
  logic output_axis_tid;
  logic psel;
  logic penable;
  logic pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;

  int seed = 32'h10e4;
  int errors = 0;
  int checks = 0;
  int mon_errors = 0;
  int mon_checks = 0;
  int ready_mode = 0;  // 0 always ready, 1 random, 2 held low.
  logic [DW+1:0] exp_a [$];  // beats are {tlast, tuser, tdata}.
  logic [DW+1:0] exp_b [$];
  int sent_pkts [2] = '{0, 0};
  int sent_beats [2] = '{0, 0};
  int sent_err = 0;
  logic in_pkt = 1'b0;
  logic pkt_tid = 1'b0;
  logic have_word;
  logic [DW+1:0] got_word;
  logic [DW+1:0] want_word;
  logic [31:0] ready_rnd;

  stream_merge_top #(
    .DATA_WIDTH (DW),
    .ADDR_WIDTH (STREAM_FIFO_ADDR_WIDTH)
  ) u_stream_merge_top (
    .input_a_clk         (input_a_clk),
    .input_a_axis_tdata  (src_tdata[0]),
    .input_a_axis_tvalid (src_tvalid[0]),
    .input_a_axis_tready (src_tready[0]),
    .input_a_axis_tlast  (src_tlast[0]),
    .input_a_axis_tuser  (src_tuser[0]),
    .input_b_clk         (input_b_clk),
    .input_b_axis_tdata  (src_tdata[1]),
    .input_b_axis_tvalid (src_tvalid[1]),
    .input_b_axis_tready (src_tready[1]),
    .input_b_axis_tlast  (src_tlast[1]),
    .input_b_axis_tuser  (src_tuser[1]),
    .output_clk          (output_clk),
    .output_rst_sync3    (output_rst_sync3),
    .output_axis_tdata   (output_axis_tdata),
    .output_axis_tvalid  (output_axis_tvalid),
    .output_axis_tready  (output_axis_tready),
    .output_axis_tlast   (output_axis_tlast),
    .output_axis_tuser   (output_axis_tuser),
    .output_axis_tid     (output_axis_tid),
    .psel                (psel),
    .penable             (penable),
    .pwrite              (pwrite),
    .paddr               (paddr),
    .pwdata              (pwdata),
    .prdata              (prdata)
  );

  initial begin
    output_clk = 1'b0;
    forever #2 output_clk = ~output_clk;
  end

  initial begin
    input_a_clk = 1'b0;
    forever #3 input_a_clk = ~input_a_clk;
  end

  initial begin
    input_b_clk = 1'b0;
    forever #5 input_b_clk = ~input_b_clk;
  end

  // sink ready pattern, changed 1 ns after each output clock edge.
  initial begin
    output_axis_tready = 1'b0;
    forever begin
      @(posedge output_clk);
      #1;
      ready_rnd = $random(seed);
      case (ready_mode)
        1: output_axis_tready = ready_rnd[0];
        2: output_axis_tready = 1'b0;
        default: output_axis_tready = 1'b1;
      endcase
    end
  end

  // inputs only move 1 ns after a rising edge, so the falling edge sees what the next edge takes.
  always @(negedge output_clk) begin
    if (!output_rst_sync3 && output_axis_tvalid && output_axis_tready) begin
      got_word = {output_axis_tlast, output_axis_tuser, output_axis_tdata};
      have_word = output_axis_tid ? (exp_b.size() != 0) : (exp_a.size() != 0);
      mon_checks++;
      assert (!in_pkt || output_axis_tid == pkt_tid) else begin
        mon_errors++;
        $display("error at %0t: beat of source %0d inside a packet of source %0d",
                 $time, output_axis_tid, pkt_tid);
      end
      assert (have_word) else begin
        mon_errors++;
        $display("error at %0t: beat 0x%h from source %0d was never sent",
                 $time, got_word, output_axis_tid);
      end
      if (have_word) begin
        if (output_axis_tid) begin
          want_word = exp_b.pop_front();
        end else begin
          want_word = exp_a.pop_front();
        end
        assert (got_word == want_word) else begin
          mon_errors++;
          $display("error at %0t: source %0d beat 0x%h, expected 0x%h",
                   $time, output_axis_tid, got_word, want_word);
        end
      end
      in_pkt = !output_axis_tlast;
      pkt_tid = output_axis_tid;
    end
  end

  task automatic wait_src_rise(input logic src);
    if (src) begin
      @(posedge input_b_clk);
    end else begin
      @(posedge input_a_clk);
    end
  endtask

  task automatic wait_src_fall(input logic src);
    if (src) begin
      @(negedge input_b_clk);
    end else begin
      @(negedge input_a_clk);
    end
  endtask

  task automatic expect_beat(input logic src, input logic [DW+1:0] word);
    if (src) begin
      exp_b.push_back(word);
    end else begin
      exp_a.push_back(word);
    end
    sent_beats[src]++;
    if (word[DW+1]) begin
      sent_pkts[src]++;
      if (word[DW]) begin
        sent_err++;  // tuser on the last beat marks the packet errored.
      end
    end
  endtask

  // entered 1 ns after a rising edge of the source clock, and leaves the same way.
  task automatic send_beat(input logic src, input logic [DW+1:0] word);
    logic taken;
    int waited;
    taken = 1'b0;
    waited = 0;
    {src_tlast[src], src_tuser[src], src_tdata[src]} = word;
    src_tvalid[src] = 1'b1;
    expect_beat(src, word);
    while (!taken && waited < 500) begin
      wait_src_fall(src);
      taken = src_tready[src];
      wait_src_rise(src);
      #1;
      waited++;
    end
    if (!taken) begin
      errors++;
      $display("timeout: source %0d beat 0x%h was never accepted", src, word);
    end
    src_tvalid[src] = 1'b0;
  endtask

  task automatic send_packet(input logic src, input int len);
    logic [31:0] rnd;
    int i;
    wait_src_rise(src);
    #1;
    for (i = 0; i < len; i++) begin
      rnd = $random(seed);
      send_beat(src, {i == len - 1, rnd[8], rnd[DW-1:0]});
    end
  endtask

  task automatic send_packets(input logic src, input int count);
    logic [31:0] rnd;
    int n;
    for (n = 0; n < count; n++) begin
      rnd = $random(seed);
      send_packet(src, int'(rnd[2:0]) + 1);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_a.size() != 0 || exp_b.size() != 0) && waited < 5000) begin
      @(posedge output_clk);
      waited++;
    end
    if (exp_a.size() != 0 || exp_b.size() != 0) begin
      errors++;
      $display("timeout: %0d beats of A and %0d of B never reached the output",
               exp_a.size(), exp_b.size());
    end
    @(posedge output_clk);
    #1;
  endtask

  // setup cycle, then access cycle; read data is taken inside the access cycle.
  task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge output_clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge output_clk);
    #1;
    penable = 1'b1;
    @(negedge output_clk);
    rdata = prdata;
    @(posedge output_clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic check_reg(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] want);
    logic [31:0] got;
    apb_access(1'b0, addr, 32'h0, got);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("error at %0t: register 0x%h reads %0d, expected %0d", $time, addr, got, want);
    end
  endtask

  `include "stream_merge_tests.svh"

  initial begin
    output_rst_sync3 = 1'b1;
    src_tdata[0] = '0;
    src_tdata[1] = '0;
    src_tvalid = '0;
    src_tlast = '0;
    src_tuser = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (2) @(posedge output_clk);
    #1;
    output_rst_sync3 = 1'b0;
    repeat (20) @(posedge output_clk);  // the FIFO reset chains settle.
    reset_test();
    single_packet_test();
    concurrent_test();
    backpressure_test();
    fill_limit_test();
    counter_clear_test();
    $display("checks %0d, errors %0d", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verification
common/stream_pkg.sv
axis_async_fifo/axis_async_fifo.sv
source/axis_packet_arbiter.sv
source/stream_stat_apb.sv
source/stream_merge_top.sv
verification/stream_merge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the stream merger testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module stream_merge_tb -o stream_merge_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/stream_merge_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
